//--- common/mips_defs.svh
/*
 * Opcode, function and sizing macros for the single-cycle MIPS core.
 * Include wherever instruction fields are decoded or memory is sized.
 */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// ======================================================================
// primary opcodes, instr[31:26]
// ======================================================================
`define OP_RTYPE 6'b000000
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100
`define OP_J     6'b000010
`define OP_JAL   6'b000011

// ======================================================================
// R-type function codes, instr[5:0]
// ======================================================================
`define FN_ADD   6'b100000
`define FN_SUB   6'b100010
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_SLT   6'b101010
`define FN_JR    6'b001000

// jal return address goes here
`define LINK_REG 5'd31

// data SRAM word index width, 128 words
`define DMEM_ADDR_W 7

`endif

//--- common/mipsPkg.sv
/*
 * Shared types for the core datapath, register file and data SRAM.
 * Modules take these by a wildcard import in their header.
 */
`include "mips_defs.svh"

package mipsPkg;

  // ====================================================================
  // datapath widths
  // ====================================================================

  // one machine word, data or byte address
  typedef logic [31:0] word_t;

  // register index, rs/rt/rd fields
  typedef logic [4:0] regAddr_t;

  // word index into the data SRAM
  // byte address bits above the word offset
  typedef logic [`DMEM_ADDR_W-1:0] memAddr_t;

  // ====================================================================
  // ALU operation select
  // ====================================================================

  // decoded straight from opcode/funct
  // aluNone forces a zero result
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluNone
  } aluOp_t;

endpackage

//--- common/dataMemBus.sv
/*
 * Data memory bus between the core and the SRAM, with active-low enables.
 * Read data is combinational, writes land on the clock edge.
 */
`timescale 1ns/1ps

interface dataMemBus
  import mipsPkg::*;
();

  // enables, all active low
  logic     cen;
  logic     wen;
  logic     oen;

  // word address and data
  memAddr_t addr;
  word_t    wdata;
  word_t    rdata;

  // core side is the master
  modport core (output cen, wen, oen, addr, wdata, input rdata);

  // SRAM side answers with read data
  modport memory (input cen, wen, oen, addr, wdata, output rdata);

endinterface

//--- core/controlUnit.sv
/*
 * Main decoder: opcode and function field to datapath selects and ALU op.
 * Purely combinational, one instruction per cycle.
 */
`timescale 1ns/1ps
`include "mips_defs.svh"

module controlUnit
  import mipsPkg::*;
(
  input  logic [5:0] opcode,
  input  logic [5:0] funct,
  output logic       regDst,
  output logic       aluSrc,
  output logic       memToReg,
  output logic       regWrite,
  output logic       memRead,
  output logic       memWrite,
  output logic       jump,
  output logic       branch,
  output logic       link,
  output logic       regJump,
  output aluOp_t     aluOp
);

  always_comb begin
    // safe defaults, nothing written
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    jump     = 1'b0;
    branch   = 1'b0;
    link     = 1'b0;
    regJump  = 1'b0;
    aluOp    = aluNone;

    case (opcode)
      `OP_RTYPE: begin
        // rd is the destination for all R-type
        regDst = 1'b1;
        case (funct)
          `FN_ADD: begin
            aluOp    = aluAdd;
            regWrite = 1'b1;
          end
          `FN_SUB: begin
            aluOp    = aluSub;
            regWrite = 1'b1;
          end
          `FN_AND: begin
            aluOp    = aluAnd;
            regWrite = 1'b1;
          end
          `FN_OR: begin
            aluOp    = aluOr;
            regWrite = 1'b1;
          end
          `FN_SLT: begin
            aluOp    = aluSlt;
            regWrite = 1'b1;
          end
          // jr only redirects the pc
          `FN_JR: regJump = 1'b1;
          default: aluOp = aluNone;
        endcase
      end
      `OP_LW: begin
        // base + offset, result from memory into rt
        aluSrc   = 1'b1;
        aluOp    = aluAdd;
        memRead  = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      `OP_SW: begin
        aluSrc   = 1'b1;
        aluOp    = aluAdd;
        memWrite = 1'b1;
      end
      `OP_BEQ: begin
        // subtract, zero flag decides
        aluOp  = aluSub;
        branch = 1'b1;
      end
      `OP_J: jump = 1'b1;
      `OP_JAL: begin
        // pc+4 into r31
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: aluOp = aluNone;
    endcase
  end

endmodule

//--- core/registerFile.sv
/*
 * General-purpose registers: two combinational reads, one clocked write.
 * Register 0 is hardwired to zero.
 */
`timescale 1ns/1ps

module registerFile
  import mipsPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     writeEn,
  input  regAddr_t readAddrA,
  input  regAddr_t readAddrB,
  input  regAddr_t writeAddr,
  input  word_t    writeData,
  output word_t    readDataA,
  output word_t    readDataB
);

  // r1..r31, no storage for r0
  word_t regs [1:31];

  // ======================================================================
  // write port
  // ======================================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      // writes to r0 dropped here
      regs[writeAddr] <= writeData;
    end
  end

  // read ports, r0 reads as zero
  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

//--- core/aluUnit.sv
/*
 * 32-bit ALU for add, sub, and, or and unsigned set-less-than.
 * Combinational, zero flag follows the result.
 */
`timescale 1ns/1ps

module aluUnit
  import mipsPkg::*;
(
  input  word_t  operandA,
  input  word_t  operandB,
  input  aluOp_t op,
  output word_t  result,
  output logic   zero
);

  always_comb begin
    case (op)
      aluAdd: result = operandA + operandB;
      // beq compares through this path
      aluSub: result = operandA - operandB;
      aluAnd: result = operandA & operandB;
      aluOr:  result = operandA | operandB;
      // unsigned compare
      aluSlt: begin
        result = '0;
        result[0] = (operandA < operandB);
      end
      default: result = '0;
    endcase
  end

  // true for any zero result, not only sub
  assign zero = (result == '0);

endmodule

//--- core/fetchUnit.sv
/*
 * Program counter and next-address selection.
 * pc advances once per cycle by jump, branch, register jump or pc+4.
 */
`timescale 1ns/1ps

module fetchUnit
  import mipsPkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        jump,
  input  logic        branchTaken,
  input  logic        regJump,
  input  logic [25:0] jumpTarget,
  input  word_t       branchOffset,
  input  word_t       regTarget,
  output word_t       pc,
  output word_t       pcPlus4
);

  word_t pcReg;
  word_t branchAddr;
  word_t nextPc;

  assign pcPlus4    = pcReg + 32'd4;
  // offset arrives sign-extended, words to bytes
  assign branchAddr = pcPlus4 + (branchOffset << 2);

  // ======================================================================
  // next address, priority order
  // ======================================================================
  always_comb begin
    if (jump) begin
      // region of pc+4, target in words
      nextPc = {pcPlus4[31:28], jumpTarget, 2'b00};
    end else if (branchTaken) begin
      nextPc = branchAddr;
    end else if (regJump) begin
      nextPc = regTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else begin
      pcReg <= nextPc;
    end
  end

  assign pc = pcReg;

endmodule

//--- core/mipsCore.sv
/*
 * Single-cycle datapath: fetch, decode, register file, ALU and memory access.
 * Drives the data bus as master and reports each register writeback.
 */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mipsCore
  import mipsPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  word_t    instr,
  output word_t    instrAddr,
  dataMemBus.core  dmem,
  output logic     wbEn,
  output regAddr_t wbAddr,
  output word_t    wbData
);

  // ======================================================================
  // instruction fields
  // ======================================================================
  logic [5:0]  opcode;
  logic [5:0]  funct;
  regAddr_t    rs;
  regAddr_t    rt;
  regAddr_t    rd;
  logic [15:0] imm16;
  logic [25:0] jumpTarget;
  word_t       signExt;

  // decoder outputs
  logic   regDst;
  logic   aluSrc;
  logic   memToReg;
  logic   regWrite;
  logic   memRead;
  logic   memWrite;
  logic   jump;
  logic   branch;
  logic   link;
  logic   regJump;
  aluOp_t aluOp;

  // datapath
  word_t    readDataA;
  word_t    readDataB;
  word_t    aluOperandB;
  word_t    aluResult;
  logic     aluZero;
  word_t    pc;
  word_t    pcPlus4;
  regAddr_t destReg;
  word_t    writeData;

  assign opcode     = instr[31:26];
  assign rs         = instr[25:21];
  assign rt         = instr[20:16];
  assign rd         = instr[15:11];
  assign funct      = instr[5:0];
  assign imm16      = instr[15:0];
  assign jumpTarget = instr[25:0];
  assign signExt    = {{16{imm16[15]}}, imm16};

  controlUnit ctrlInst (
    .opcode(opcode), .funct(funct), .regDst(regDst), .aluSrc(aluSrc),
    .memToReg(memToReg), .regWrite(regWrite), .memRead(memRead),
    .memWrite(memWrite), .jump(jump), .branch(branch), .link(link),
    .regJump(regJump), .aluOp(aluOp)
  );

  // destination: jal -> r31, R-type -> rd, else rt
  assign destReg = link ? `LINK_REG : (regDst ? rd : rt);

  // writeback source: link, memory, or ALU
  assign writeData = link ? pcPlus4 : (memToReg ? dmem.rdata : aluResult);

  registerFile regFileInst (
    .clk(clk), .rst(rst), .writeEn(regWrite), .readAddrA(rs), .readAddrB(rt),
    .writeAddr(destReg), .writeData(writeData), .readDataA(readDataA),
    .readDataB(readDataB)
  );

  // immediate for lw/sw address arithmetic
  assign aluOperandB = aluSrc ? signExt : readDataB;

  aluUnit aluInst (
    .operandA(readDataA), .operandB(aluOperandB), .op(aluOp),
    .result(aluResult), .zero(aluZero)
  );

  fetchUnit fetchInst (
    .clk(clk), .rst(rst), .jump(jump), .branchTaken(branch & aluZero),
    .regJump(regJump), .jumpTarget(jumpTarget), .branchOffset(signExt),
    .regTarget(readDataA), .pc(pc), .pcPlus4(pcPlus4)
  );

  assign instrAddr = pc;

  // ======================================================================
  // data bus, active-low enables
  // ======================================================================
  assign dmem.cen   = ~(memRead | memWrite);
  assign dmem.wen   = ~memWrite;
  assign dmem.oen   = ~memRead;
  // drop the byte offset
  assign dmem.addr  = memAddr_t'(aluResult[`DMEM_ADDR_W+1:2]);
  assign dmem.wdata = readDataB;

  // observed writeback, r0 writes hidden
  assign wbEn   = regWrite && (destReg != '0);
  assign wbAddr = destReg;
  assign wbData = writeData;

endmodule

//--- hw/dataSram.sv
/*
 * Word-addressed data SRAM with active-low chip, write and output enables.
 * Combinational read, write on the rising clock edge.
 */
`timescale 1ns/1ps
`include "mips_defs.svh"

module dataSram
  import mipsPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  dataMemBus.memory mem
);

  localparam int Depth = 1 << `DMEM_ADDR_W;

  // contents undefined until written
  word_t memArray [0:Depth-1];

  // ======================================================================
  // write port
  // ======================================================================

  // chip and write enable both low
  // held off while in reset
  always_ff @(posedge clk) begin
    if (rst && !mem.cen && !mem.wen) begin
      memArray[mem.addr] <= mem.wdata;
    end
  end

  // read port, zero when not selected
  assign mem.rdata = (!mem.cen && !mem.oen) ? memArray[mem.addr] : '0;

endmodule

//--- hw/mipsSystem.sv
/*
 * Top level: MIPS core plus data SRAM joined by the data bus.
 * Instruction memory sits outside, fed through instrAddr/instr.
 */
`timescale 1ns/1ps

module mipsSystem
  import mipsPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  word_t    instr,
  output word_t    instrAddr,
  output logic     wbEn,
  output regAddr_t wbAddr,
  output word_t    wbData
);

  // core to SRAM
  dataMemBus dmemBus ();

  mipsCore coreInst (
    .clk      (clk),
    .rst      (rst),
    .instr    (instr),
    .instrAddr(instrAddr),
    .dmem     (dmemBus.core),
    // writeback observation
    .wbEn     (wbEn),
    .wbAddr   (wbAddr),
    .wbData   (wbData)
  );

  dataSram sramInst (
    .clk(clk),
    .rst(rst),
    .mem(dmemBus.memory)
  );

endmodule

//--- tests/programTable.svh
/*
 * Program for the MIPS testbench, built at time zero into the row table.
 * Included in the testbench module body, uses its instruction model tasks.
 */

// instruction word encoders
function automatic word_t rFormat(regAddr_t rs, regAddr_t rt, regAddr_t rd, logic [5:0] fn);
  return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t iFormat(logic [5:0] op, regAddr_t rs, regAddr_t rt,
                                  logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic word_t jFormat(logic [5:0] op, logic [25:0] target);
  return {op, target};
endfunction

// jump to value-4 and jal back so r31 holds value before the copy into rd
task automatic loadValue(input regAddr_t rd, input word_t value);
  word_t home;
  home = pcModel;
  jumpInstr(`OP_J, value - 4);
  jumpInstr(`OP_JAL, home + 8);
  aluInstr(`FN_ADD, rd, `LINK_REG, 5'd0);
endtask

task automatic buildProgram();
  word_t valA;
  word_t valB;
  pcModel = '0;
  for (int i = 0; i < 32; i++) regModel[i] = '0;
  // word aligned and well inside the jump region
  valA = 32'h0010_0000 | ($random(seed) & 32'h000F_FFFC);
  valB = 32'h0010_0000 | ($random(seed) & 32'h000F_FFFC);
  if (valB == valA) valB = valA + 32'h40;

  // nop straight out of reset
  addStep('0, 1'b0, '0, '0, pcModel + 4);
  loadValue(5'd1, valA);
  loadValue(5'd2, valB);

  // ==================================================================
  // arithmetic and logic on the random operands
  // ==================================================================
  aluInstr(`FN_ADD, 5'd3, 5'd1, 5'd2);
  aluInstr(`FN_SUB, 5'd4, 5'd1, 5'd2);
  aluInstr(`FN_AND, 5'd5, 5'd1, 5'd2);
  aluInstr(`FN_OR,  5'd6, 5'd1, 5'd2);
  aluInstr(`FN_SLT, 5'd7, 5'd1, 5'd2);
  aluInstr(`FN_SLT, 5'd8, 5'd2, 5'd1);
  // r0 write hidden and r0 read as zero
  aluInstr(`FN_ADD, 5'd0, 5'd1, 5'd2);
  aluInstr(`FN_ADD, 5'd9, 5'd0, 5'd1);
  // negative operand tells unsigned slt from signed
  aluInstr(`FN_SUB, 5'd14, 5'd0, 5'd1);
  aluInstr(`FN_SLT, 5'd15, 5'd14, 5'd1);

  // store then reload at absolute and based addresses
  memInstr(`OP_SW, 5'd3, 5'd0, 16'h0010);
  memInstr(`OP_SW, 5'd4, 5'd0, 16'h0014);
  memInstr(`OP_LW, 5'd10, 5'd0, 16'h0010);
  memInstr(`OP_LW, 5'd11, 5'd0, 16'h0014);
  memInstr(`OP_SW, 5'd6, 5'd1, 16'hFFF8);
  memInstr(`OP_LW, 5'd12, 5'd1, 16'hFFF8);

  // taken then not taken
  beqInstr(5'd10, 5'd3, 16'h0003);
  beqInstr(5'd1, 5'd2, 16'h0005);

  // call a subroutine and return through r31
  jumpInstr(`OP_JAL, 32'h0000_0400);
  aluInstr(`FN_ADD, 5'd13, 5'd1, 5'd1);
  jrInstr(`LINK_REG);
  addStep('0, 1'b0, '0, '0, pcModel + 4);
endtask

//--- tests/mipsSystemTb.sv
/*
 * Testbench for the single-cycle MIPS system. Plays instruction memory,
 * one table row per cycle, and checks fetch address and register writeback.
 */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mipsSystemTb
  import mipsPkg::*;
();

  localparam int ClkPeriod   = 100;
  localparam int ResetCycles = 8;

  // one executed instruction and what it should show
  typedef struct {
    word_t    addr;
    word_t    instr;
    logic     wbEn;
    regAddr_t wbAddr;
    word_t    wbData;
  } stepRow_t;

  logic     clk;
  logic     rst;
  word_t    instr;
  word_t    instrAddr;
  logic     wbEn;
  regAddr_t wbAddr;
  word_t    wbData;

  stepRow_t programRows [$];
  // architectural state as the table builder sees it
  word_t    regModel [0:31];
  word_t    memModel [0:(1 << `DMEM_ADDR_W) - 1];
  word_t    pcModel;
  integer   seed       = 4567;
  int       errorCount = 0;
  bit       tableReady = 1'b0;

  mipsSystem mipsSystem_inst (
    .clk      (clk),
    .rst      (rst),
    .instr    (instr),
    .instrAddr(instrAddr),
    .wbEn     (wbEn),
    .wbAddr   (wbAddr),
    .wbData   (wbData)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  `include "programTable.svh"

  // ====================================================================
  // instruction model with one task per instruction class
  // ====================================================================

  // push a row at the model pc then commit and advance
  task automatic addStep(input word_t ins, input logic en, input regAddr_t wa,
                         input word_t wd, input word_t nextPc);
    programRows.push_back('{pcModel, ins, en, wa, wd});
    if (en) regModel[wa] = wd;
    pcModel = nextPc;
  endtask

  task automatic aluInstr(input logic [5:0] fn, input regAddr_t rd, rs, rt);
    word_t a;
    word_t b;
    word_t res;
    a = regModel[rs];
    b = regModel[rt];
    case (fn)
      `FN_ADD: res = a + b;
      `FN_SUB: res = a - b;
      `FN_AND: res = a & b;
      `FN_OR:  res = a | b;
      // slt compares unsigned
      default: res = {31'b0, a < b};
    endcase
    addStep(rFormat(rs, rt, rd, fn), rd != 5'd0, rd, res, pcModel + 4);
  endtask

  // lw or sw with word index from bits 8..2 of base + offset
  task automatic memInstr(input logic [5:0] op, input regAddr_t rt, base,
                          input logic [15:0] off);
    word_t    ea;
    memAddr_t idx;
    ea  = regModel[base] + {{16{off[15]}}, off};
    idx = ea[`DMEM_ADDR_W + 1:2];
    if (op == `OP_SW) begin
      memModel[idx] = regModel[rt];
      addStep(iFormat(op, base, rt, off), 1'b0, '0, '0, pcModel + 4);
    end else begin
      addStep(iFormat(op, base, rt, off), rt != 5'd0, rt, memModel[idx], pcModel + 4);
    end
  endtask

  task automatic beqInstr(input regAddr_t rs, rt, input logic [15:0] off);
    word_t target;
    target = pcModel + 4;
    if (regModel[rs] == regModel[rt]) target = target + ({{16{off[15]}}, off} << 2);
    addStep(iFormat(`OP_BEQ, rs, rt, off), 1'b0, '0, '0, target);
  endtask

  // j or jal with region bits taken from pc+4
  task automatic jumpInstr(input logic [5:0] op, input word_t dest);
    word_t link;
    link = pcModel + 4;
    addStep(jFormat(op, dest[27:2]), op == `OP_JAL, `LINK_REG, link,
            {link[31:28], dest[27:0]});
  endtask

  task automatic jrInstr(input regAddr_t rs);
    addStep(rFormat(rs, 5'd0, 5'd0, `FN_JR), 1'b0, '0, '0, regModel[rs]);
  endtask

  task automatic checkValue(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
      errorCount++;
    end
  endtask

  // ====================================================================
  // reset then feed one row per clock
  // ====================================================================
  initial begin
    clk   = 1'b0;
    rst   = 1'b0;
    instr = '0;
    buildProgram();
    tableReady = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    // release edge still sees reset so pc stays 0 for row 0
    rst <= 1'b1;
    foreach (programRows[i]) begin
      instr <= programRows[i].instr;
      // let pc and the combinational writeback settle
      #(ClkPeriod / 4);
      if (instrAddr !== programRows[i].addr) begin
        $display("Control flow diverged at step %0d: fetch address %h, table expects %h",
                 i, instrAddr, programRows[i].addr);
        errorCount++;
        break;
      end
      checkValue("wbEn", programRows[i].wbEn, wbEn);
      if (programRows[i].wbEn) begin
        checkValue("wbAddr", programRows[i].wbAddr, wbAddr);
        checkValue("wbData", programRows[i].wbData, wbData);
      end
      @(posedge clk);
    end
    $display("Checks done, %0d errors", errorCount);
    if (errorCount == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // watchdog over the table length plus margin
  initial begin
    wait (tableReady);
    #((programRows.size() + 20) * ClkPeriod);
    $display("Timeout: run did not complete within %0d cycles", programRows.size() + 20);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- mipsSystem.f
+incdir+common
+incdir+tests
common/mipsPkg.sv
common/dataMemBus.sv
core/controlUnit.sv
core/registerFile.sv
core/aluUnit.sv
core/fetchUnit.sv
core/mipsCore.sv
hw/dataSram.sv
hw/mipsSystem.sv
tests/mipsSystemTb.sv

//--- Bender.yml
package:
  name: mips_system

export_include_dirs:
  - common

sources:
  - files:
      - common/mipsPkg.sv
      - common/dataMemBus.sv
      - core/controlUnit.sv
      - core/registerFile.sv
      - core/aluUnit.sv
      - core/fetchUnit.sv
      - core/mipsCore.sv
      - hw/dataSram.sv
      - hw/mipsSystem.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/mipsSystemTb.sv
